//--- logic/mmu_pkg.sv
package mmu_pkg;

  // Address split
  localparam int VADDR_W       = 20;
  localparam int PAGE_OFFSET_W = 12;
  localparam int VTAG_W        = 8;
  localparam int PTAG_W        = 8;

  // Physical attributes carried in the ptag
  localparam int DID_W        = 2;
  localparam int UNCACHED_BIT = 5;

  localparam int DWORD_W = 64;

  typedef enum logic [1:0] {
    e_priv_user       = 2'b00,
    e_priv_supervisor = 2'b01,
    e_priv_machine    = 2'b11
  } priv_e;

  typedef enum logic {
    e_op_load  = 1'b0,
    e_op_store = 1'b1
  } mem_op_e;

  typedef struct packed {
    mem_op_e              op;
    logic [VADDR_W-1:0]   vaddr;
    logic [DWORD_W-1:0]   data;
  } mmu_cmd_s;

  // Leaf PTE fields kept by the TLB
  typedef struct packed {
    logic [PTAG_W-1:0] ptag;
    logic              u;
    logic              w;
    logic              d;
  } tlb_entry_s;

  typedef enum logic [2:0] {
    e_ok                 = 3'd0,
    e_tlb_miss           = 3'd1,
    e_load_page_fault    = 3'd2,
    e_store_page_fault   = 3'd3,
    e_load_access_fault  = 3'd4,
    e_store_access_fault = 3'd5
  } fault_e;

  typedef struct packed {
    fault_e             status;
    logic [DWORD_W-1:0] data;
  } mem_resp_s;

endpackage

//--- logic/dtlb.sv
`timescale 1ns/1ps

module dtlb #(
  parameter int TLB_ELS = 4
) (
  input  logic                        clk_i,
  input  logic                        reset_i,

  input  logic                        lookup_v_i,
  input  logic [mmu_pkg::VTAG_W-1:0]  lookup_vtag_i,

  input  logic                        fill_v_i,
  input  logic [mmu_pkg::VTAG_W-1:0]  fill_vtag_i,
  input  mmu_pkg::tlb_entry_s         fill_entry_i,
  input  logic                        flush_i,

  output logic                        hit_o,
  output mmu_pkg::tlb_entry_s         entry_o
);

  localparam int PTR_W = (TLB_ELS > 1) ? $clog2(TLB_ELS) : 1;

  logic [TLB_ELS-1:0]         valid_r;
  logic [mmu_pkg::VTAG_W-1:0] tag_r   [TLB_ELS];
  mmu_pkg::tlb_entry_s        entry_r [TLB_ELS];
  logic [PTR_W-1:0]           victim_r;

  logic [TLB_ELS-1:0]         lookup_match;
  logic [TLB_ELS-1:0]         fill_match;
  mmu_pkg::tlb_entry_s        lookup_entry;
  logic [PTR_W-1:0]           fill_idx;
  logic                       fill_hit;

  // Tag compare for both the lookup and the fill port
  always_comb begin
    lookup_entry = '0;
    fill_idx     = victim_r;
    fill_hit     = 1'b0;
    for (int i = 0; i < TLB_ELS; i++) begin
      lookup_match[i] = valid_r[i] && (tag_r[i] == lookup_vtag_i);
      fill_match[i]   = valid_r[i] && (tag_r[i] == fill_vtag_i);
      if (lookup_match[i]) begin
        lookup_entry = entry_r[i];
      end
      if (fill_match[i]) begin
        fill_idx = PTR_W'(i);
        fill_hit = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_r  <= '0;
      victim_r <= '0;
    end else if (fill_v_i) begin
      valid_r[fill_idx] <= 1'b1;
      // Refill of a present tag keeps the victim where it is
      if (!fill_hit) begin
        victim_r <= (victim_r == PTR_W'(TLB_ELS - 1)) ? '0 : victim_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i && !flush_i) begin
      tag_r[fill_idx]   <= fill_vtag_i;
      entry_r[fill_idx] <= fill_entry_i;
    end
  end

  // Lookup result lands one cycle after the request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hit_o <= 1'b0;
    end else begin
      hit_o <= lookup_v_i && (|lookup_match);
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_v_i) begin
      entry_o <= lookup_entry;
    end
  end

endmodule

//--- logic/access_check.sv
`timescale 1ns/1ps

module access_check (
  input  mmu_pkg::mem_op_e            op_i,
  input  mmu_pkg::tlb_entry_s         entry_i,
  input  logic                        hit_i,

  input  logic                        translation_en_i,
  input  mmu_pkg::priv_e              priv_i,
  input  logic                        sum_i,
  input  logic                        uncached_mode_i,

  input  logic [mmu_pkg::PTAG_W-1:0]  ptag_i,
  output mmu_pkg::fault_e             status_o
);

  logic is_store;
  logic priv_fault;
  logic write_fault;
  logic domain_fault;
  logic mode_fault;

  assign is_store = (op_i == mmu_pkg::e_op_store);

  // S-mode touching user pages without SUM, or U-mode on a supervisor page
  assign priv_fault = ((priv_i == mmu_pkg::e_priv_supervisor) && !sum_i && entry_i.u)
                   || ((priv_i == mmu_pkg::e_priv_user) && !entry_i.u);

  assign write_fault = is_store && (!entry_i.w || !entry_i.d);

  // Only domain zero is reachable
  assign domain_fault = (ptag_i[mmu_pkg::PTAG_W-1 -: mmu_pkg::DID_W] != '0);
  assign mode_fault   = uncached_mode_i && !ptag_i[mmu_pkg::UNCACHED_BIT];

  always_comb begin
    if (translation_en_i && !hit_i) begin
      status_o = mmu_pkg::e_tlb_miss;
    end else if (translation_en_i && (priv_fault || write_fault)) begin
      status_o = is_store ? mmu_pkg::e_store_page_fault : mmu_pkg::e_load_page_fault;
    end else if (domain_fault || mode_fault) begin
      status_o = is_store ? mmu_pkg::e_store_access_fault : mmu_pkg::e_load_access_fault;
    end else begin
      status_o = mmu_pkg::e_ok;
    end
  end

endmodule

//--- logic/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
  parameter  int RAM_WORDS = 64,
  localparam int ADDR_W    = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1
) (
  input  logic                         clk_i,
  input  logic [ADDR_W-1:0]            addr_i,
  input  logic                         we_i,
  input  logic [mmu_pkg::DWORD_W-1:0]  wdata_i,
  output logic [mmu_pkg::DWORD_W-1:0]  rdata_o
);

  // Starts out all zero
  logic [mmu_pkg::DWORD_W-1:0] mem_r [RAM_WORDS] = '{default: '0};

  // A write also returns its own data on the read port
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_r[addr_i] <= wdata_i;
      rdata_o       <= wdata_i;
    end else begin
      rdata_o <= mem_r[addr_i];
    end
  end

endmodule

//--- logic/mem_top.sv
`timescale 1ns/1ps

module mem_top #(
  parameter int TLB_ELS   = 4,
  parameter int RAM_WORDS = 64
) (
  input  logic                        clk_i,
  input  logic                        reset_i,

  input  logic                        cmd_v_i,
  input  mmu_pkg::mmu_cmd_s           cmd_i,
  input  logic                        poison_i,

  input  logic                        fill_v_i,
  input  logic [mmu_pkg::VTAG_W-1:0]  fill_vtag_i,
  input  mmu_pkg::tlb_entry_s         fill_entry_i,
  input  logic                        flush_i,

  input  logic                        translation_en_i,
  input  mmu_pkg::priv_e              priv_i,
  input  logic                        sum_i,
  input  logic                        uncached_mode_i,

  output logic                        resp_v_o,
  output mmu_pkg::mem_resp_s          resp_o
);

  localparam int RAM_ADDR_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
  localparam int PADDR_W    = mmu_pkg::PTAG_W + mmu_pkg::PAGE_OFFSET_W;

  // Stage 1 command and the configuration it was issued under
  logic                        s1_v_r;
  mmu_pkg::mmu_cmd_s           s1_cmd_r;
  logic                        s1_xlate_r;
  mmu_pkg::priv_e              s1_priv_r;
  logic                        s1_sum_r;
  logic                        s1_uncached_r;

  logic                        tlb_hit;
  mmu_pkg::tlb_entry_s         tlb_entry;
  mmu_pkg::fault_e             s1_status;
  logic [mmu_pkg::PTAG_W-1:0]  s1_ptag;
  logic [PADDR_W-1:0]          s1_paddr;
  logic                        ram_we;
  logic [mmu_pkg::DWORD_W-1:0] ram_rdata;

  // Stage 2
  logic                        s2_v_r;
  mmu_pkg::fault_e             s2_status_r;
  mmu_pkg::mem_op_e            s2_op_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_r <= 1'b0;
      s2_v_r <= 1'b0;
    end else begin
      s1_v_r <= cmd_v_i;
      s2_v_r <= s1_v_r && !poison_i;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_cmd_r      <= cmd_i;
    s1_xlate_r    <= translation_en_i;
    s1_priv_r     <= priv_i;
    s1_sum_r      <= sum_i;
    s1_uncached_r <= uncached_mode_i;
    s2_status_r   <= s1_status;
    s2_op_r       <= s1_cmd_r.op;
  end

  dtlb #(
    .TLB_ELS(TLB_ELS)
  ) u_dtlb (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .lookup_v_i   (cmd_v_i),
    .lookup_vtag_i(cmd_i.vaddr[mmu_pkg::VADDR_W-1 -: mmu_pkg::VTAG_W]),
    .fill_v_i     (fill_v_i),
    .fill_vtag_i  (fill_vtag_i),
    .fill_entry_i (fill_entry_i),
    .flush_i      (flush_i),
    .hit_o        (tlb_hit),
    .entry_o      (tlb_entry)
  );

  // Bypass maps the vtag straight through
  assign s1_ptag  = s1_xlate_r ? tlb_entry.ptag
                               : s1_cmd_r.vaddr[mmu_pkg::VADDR_W-1 -: mmu_pkg::VTAG_W];
  assign s1_paddr = {s1_ptag, s1_cmd_r.vaddr[mmu_pkg::PAGE_OFFSET_W-1:0]};

  access_check u_access_check (
    .op_i            (s1_cmd_r.op),
    .entry_i         (tlb_entry),
    .hit_i           (tlb_hit),
    .translation_en_i(s1_xlate_r),
    .priv_i          (s1_priv_r),
    .sum_i           (s1_sum_r),
    .uncached_mode_i (s1_uncached_r),
    .ptag_i          (s1_ptag),
    .status_o        (s1_status)
  );

  assign ram_we = s1_v_r && !poison_i && (s1_cmd_r.op == mmu_pkg::e_op_store)
               && (s1_status == mmu_pkg::e_ok);

  data_ram #(
    .RAM_WORDS(RAM_WORDS)
  ) u_data_ram (
    .clk_i  (clk_i),
    .addr_i (s1_paddr[3 +: RAM_ADDR_W]),
    .we_i   (ram_we),
    .wdata_i(s1_cmd_r.data),
    .rdata_o(ram_rdata)
  );

  // Only a clean load carries data back
  assign resp_v_o      = s2_v_r;
  assign resp_o.status = s2_status_r;
  assign resp_o.data   = ((s2_status_r == mmu_pkg::e_ok) && (s2_op_r == mmu_pkg::e_op_load))
                       ? ram_rdata : '0;

endmodule

//--- tests/mem_top_asserts.sv
`timescale 1ns/1ps

module mem_top_asserts (
  input logic clk_i,
  input logic reset_i,
  input logic cmd_v_i,
  input logic resp_v_o
);

  // Fixed latency of two cycles from issue
  assert property (@(posedge clk_i) disable iff (reset_i) resp_v_o |-> $past(cmd_v_i, 2))
    else $error("resp_v_o without cmd_v_i two cycles earlier");

  assert property (@(posedge clk_i) reset_i |=> !resp_v_o)
    else $error("resp_v_o high during reset");

  // Pipe is still empty right after reset
  assert property (@(posedge clk_i) $fell(reset_i) |=> !resp_v_o)
    else $error("resp_v_o high in the first cycle after reset");

endmodule

bind mem_top mem_top_asserts u_asserts (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .cmd_v_i (cmd_v_i),
  .resp_v_o(resp_v_o)
);

//--- tests/mem_top_tb.sv
`timescale 1ns/1ps

module mem_top_tb;

  localparam int TLB_ELS     = 4;
  localparam int RAM_WORDS   = 64;
  localparam int RAND_CYCLES = 2000;
  // Directed sections, poison run, random mix, four RAM sweeps and drain
  localparam int TOTAL_CYCLES = 64 + 20 + 8 * 13 + 20 + 64 + RAND_CYCLES + 4 * RAM_WORDS + 3;

  // Command together with the levels and TLB result seen at issue
  typedef struct packed {
    mmu_pkg::mmu_cmd_s   cmd;
    logic                xlate;
    mmu_pkg::priv_e      priv;
    logic                sum;
    logic                unc;
    logic                hit;
    mmu_pkg::tlb_entry_s entry;
  } issue_s;

  logic clk_i = 1'b0;
  logic reset_i, cmd_v_i, poison_i, fill_v_i, flush_i;
  logic translation_en_i, sum_i, uncached_mode_i;
  mmu_pkg::mmu_cmd_s          cmd_i;
  logic [mmu_pkg::VTAG_W-1:0] fill_vtag_i;
  mmu_pkg::tlb_entry_s        fill_entry_i;
  mmu_pkg::priv_e             priv_i;
  logic                       resp_v_o;
  mmu_pkg::mem_resp_s         resp_o;

  logic [mmu_pkg::DWORD_W-1:0] model_ram [RAM_WORDS] = '{default: '0};
  logic [TLB_ELS-1:0]          m_valid = '0;
  logic [mmu_pkg::VTAG_W-1:0]  m_tag [TLB_ELS];
  mmu_pkg::tlb_entry_s         m_entry [TLB_ELS];
  int                          m_victim = 0;
  logic                        pend_v = 1'b0;
  issue_s                      pend;
  int                          pend_cycle;
  mmu_pkg::mem_resp_s          exp_q [$];
  int                          due_q [$];
  int                          cycle_cnt = 0;

  always #2 clk_i = ~clk_i;
  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  mem_top #(.TLB_ELS(TLB_ELS), .RAM_WORDS(RAM_WORDS)) UUT (.*);

  function automatic mmu_pkg::mem_resp_s expected_resp(issue_s c);
    logic [mmu_pkg::PTAG_W-1:0] ptag;
    logic store, priv_bad;
    mmu_pkg::mem_resp_s r;
    store = (c.cmd.op == mmu_pkg::e_op_store);
    ptag = c.xlate ? c.entry.ptag : c.cmd.vaddr[19:12];
    priv_bad = (c.priv == mmu_pkg::e_priv_user) ? !c.entry.u
             : (c.priv == mmu_pkg::e_priv_supervisor) && !c.sum && c.entry.u;
    r.data = '0;
    if (c.xlate && !c.hit) r.status = mmu_pkg::e_tlb_miss;
    else if (c.xlate && (priv_bad || (store && !(c.entry.w && c.entry.d))))
      r.status = store ? mmu_pkg::e_store_page_fault : mmu_pkg::e_load_page_fault;
    else if (ptag[7:6] != 2'b00 || (c.unc && !ptag[5]))
      r.status = store ? mmu_pkg::e_store_access_fault : mmu_pkg::e_load_access_fault;
    else begin
      r.status = mmu_pkg::e_ok;
      if (!store) r.data = model_ram[c.cmd.vaddr[8:3]];
    end
    return r;
  endfunction

  function automatic mmu_pkg::priv_e priv_of(int n);
    case (n)
      0: return mmu_pkg::e_priv_user;
      1: return mmu_pkg::e_priv_supervisor;
      default: return mmu_pkg::e_priv_machine;
    endcase
  endfunction

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_status(input mmu_pkg::fault_e want, input mmu_pkg::fault_e got);
    if (got !== want) begin
      $display("ERR t=%0t resp_o.status expected %s got %s", $time, want.name(), got.name());
      abort_run();
    end
  endtask

  task automatic compare_data(input logic [mmu_pkg::DWORD_W-1:0] want,
                              input logic [mmu_pkg::DWORD_W-1:0] got);
    if (got !== want) begin
      $display("ERR t=%0t resp_o.data expected %h got %h", $time, want, got);
      abort_run();
    end
  endtask

  task automatic check_latency(input int want, input int got);
    if (got != want) begin
      $display("ERR t=%0t resp_v_o cycle expected %0d got %0d", $time, want, got);
      abort_run();
    end
  endtask

  // Model one cycle of the current inputs, then move to the next drive point
  task automatic advance();
    mmu_pkg::mem_resp_s r;
    int idx;
    logic present;
    if (pend_v && !poison_i) begin
      r = expected_resp(pend);
      exp_q.push_back(r);
      due_q.push_back(pend_cycle + 2);
      if (r.status == mmu_pkg::e_ok && pend.cmd.op == mmu_pkg::e_op_store)
        model_ram[pend.cmd.vaddr[8:3]] = pend.cmd.data;
    end
    pend_v = cmd_v_i;
    if (cmd_v_i) begin
      pend = '{cmd_i, translation_en_i, priv_i, sum_i, uncached_mode_i, 1'b0, '0};
      pend_cycle = cycle_cnt;
      for (int i = 0; i < TLB_ELS; i++) begin
        if (m_valid[i] && m_tag[i] == cmd_i.vaddr[19:12]) begin
          pend.hit = 1'b1;
          pend.entry = m_entry[i];
        end
      end
    end
    if (flush_i) begin
      m_valid = '0;
      m_victim = 0;
    end else if (fill_v_i) begin
      // A present tag is overwritten in place, otherwise the victim slot is used
      idx = m_victim;
      present = 1'b0;
      for (int i = 0; i < TLB_ELS; i++) begin
        if (m_valid[i] && m_tag[i] == fill_vtag_i) begin
          idx = i;
          present = 1'b1;
        end
      end
      if (!present) m_victim = (m_victim + 1) % TLB_ELS;
      m_valid[idx] = 1'b1;
      m_tag[idx] = fill_vtag_i;
      m_entry[idx] = fill_entry_i;
    end
    @(posedge clk_i);
    #1;
    {cmd_v_i, poison_i, fill_v_i, flush_i} = '0;
  endtask

  task automatic issue_cmd(input mmu_pkg::mem_op_e op, input logic [19:0] vaddr,
                           input logic [63:0] data);
    cmd_v_i = 1'b1;
    cmd_i = '{op, vaddr, data};
    advance();
  endtask

  task automatic load_tlb(input logic [7:0] vtag, input logic [7:0] ptag, input logic [2:0] udw);
    fill_v_i = 1'b1;
    fill_vtag_i = vtag;
    fill_entry_i = {ptag, udw};
    advance();
  endtask

  task automatic set_levels(input logic xlate, input mmu_pkg::priv_e priv, input logic sum,
                            input logic unc);
    translation_en_i = xlate;
    priv_i = priv;
    sum_i = sum;
    uncached_mode_i = unc;
  endtask

  task automatic sweep_ram();
    set_levels(1'b0, mmu_pkg::e_priv_machine, 1'b0, 1'b0);
    for (int i = 0; i < RAM_WORDS; i++) issue_cmd(mmu_pkg::e_op_load, 20'(i * 8), '0);
  endtask

  function automatic logic [7:0] rand_tag();
    logic [7:0] t;
    t = {2'b00, 1'($urandom), 2'b00, 3'($urandom)};
    if ($urandom_range(0, 7) == 0) t[7:6] = 2'($urandom);
    return t;
  endfunction

  always @(negedge clk_i) begin : compare_resp
    mmu_pkg::mem_resp_s want;
    if (!reset_i && resp_v_o) begin
      if (exp_q.size() == 0) begin
        $display("Response valid at %0t with no command outstanding", $time);
        abort_run();
      end else begin
        want = exp_q.pop_front();
        check_latency(due_q.pop_front(), cycle_cnt);
        compare_status(want.status, resp_o.status);
        compare_data(want.data, resp_o.data);
      end
    end
  end

  initial begin : watchdog
    #(4 * (TOTAL_CYCLES + 200));
    $display("Timeout after %0d cycles, the tests did not finish", TOTAL_CYCLES + 200);
    abort_run();
  end

  initial begin : stimulus
    logic [19:0] addrs [32];
    void'($urandom(32'h7fd08618));
    {reset_i, cmd_v_i, poison_i, fill_v_i, flush_i} = 5'b10000;
    cmd_i = '0;
    fill_vtag_i = '0;
    fill_entry_i = '0;
    set_levels(1'b0, mmu_pkg::e_priv_machine, 1'b0, 1'b0);
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    // Bypass stores then loads, back to back
    for (int k = 0; k < 32; k++) begin
      addrs[k] = {2'b00, 6'($urandom), 12'($urandom)};
      issue_cmd(mmu_pkg::e_op_store, addrs[k], {$urandom, $urandom});
    end
    for (int k = 0; k < 32; k++) issue_cmd(mmu_pkg::e_op_load, addrs[k], '0);
    // Hits, misses, round-robin eviction and flush
    set_levels(1'b1, mmu_pkg::e_priv_machine, 1'b0, 1'b0);
    flush_i = 1'b1;
    advance();
    for (int k = 0; k < 4; k++) load_tlb(8'h10 + 8'(k), 8'h08 + 8'(k), 3'b011);
    for (int k = 0; k < 4; k++) begin
      issue_cmd(mmu_pkg::e_op_load, {8'h10 + 8'(k), 12'($urandom)}, '0);
      issue_cmd(mmu_pkg::e_op_store, {8'h10 + 8'(k), 12'($urandom)}, {$urandom, $urandom});
    end
    issue_cmd(mmu_pkg::e_op_load, {8'h20, 12'h008}, '0);
    load_tlb(8'h14, 8'h0c, 3'b011);
    for (int k = 0; k < 3; k++) issue_cmd(mmu_pkg::e_op_load, {8'h10 + 8'(k * 2), 12'h010}, '0);
    flush_i = 1'b1;
    advance();
    issue_cmd(mmu_pkg::e_op_load, {8'h12, 12'h018}, '0);
    // Page faults over every u/w/d combination
    for (int c = 0; c < 8; c++) begin
      load_tlb(8'h30, 8'h02, 3'(c));
      for (int p = 0; p < 3; p++) begin
        for (int s = 0; s < 2; s++) begin
          set_levels(1'b1, priv_of(p), 1'(s), 1'b0);
          issue_cmd(mmu_pkg::e_op_load, {8'h30, 12'($urandom)}, '0);
          issue_cmd(mmu_pkg::e_op_store, {8'h30, 12'($urandom)}, {$urandom, $urandom});
        end
      end
    end
    sweep_ram();
    // Access faults from domain and cached pages in uncached mode
    set_levels(1'b1, mmu_pkg::e_priv_machine, 1'b0, 1'b0);
    load_tlb(8'h40, 8'h41, 3'b011);
    load_tlb(8'h41, 8'h21, 3'b011);
    load_tlb(8'h42, 8'h01, 3'b011);
    for (int m = 0; m < 2; m++) begin
      for (int v = 0; v < 3; v++) begin
        set_levels(1'b1, mmu_pkg::e_priv_machine, 1'b0, 1'(m));
        issue_cmd(mmu_pkg::e_op_load, {8'h40 + 8'(v), 12'($urandom)}, '0);
        issue_cmd(mmu_pkg::e_op_store, {8'h40 + 8'(v), 12'($urandom)}, {$urandom, $urandom});
      end
    end
    set_levels(1'b0, mmu_pkg::e_priv_machine, 1'b0, 1'b1);
    issue_cmd(mmu_pkg::e_op_store, {8'h81, 12'($urandom)}, {$urandom, $urandom});
    issue_cmd(mmu_pkg::e_op_store, {8'h01, 12'($urandom)}, {$urandom, $urandom});
    issue_cmd(mmu_pkg::e_op_store, {8'h21, 12'($urandom)}, {$urandom, $urandom});
    sweep_ram();
    // Poison kills the stage-1 command
    for (int k = 0; k < 64; k++) begin
      poison_i = 1'($urandom);
      issue_cmd(mmu_pkg::mem_op_e'($urandom_range(0, 1)), {8'h00, 12'($urandom)},
                {$urandom, $urandom});
    end
    sweep_ram();
    for (int k = 0; k < RAND_CYCLES; k++) begin
      cmd_v_i = ($urandom_range(0, 3) != 0);
      cmd_i = '{mmu_pkg::mem_op_e'($urandom_range(0, 1)), {rand_tag(), 12'($urandom)},
                {$urandom, $urandom}};
      fill_v_i = ($urandom_range(0, 7) == 0);
      fill_vtag_i = rand_tag();
      fill_entry_i = {rand_tag(), 3'($urandom)};
      flush_i = ($urandom_range(0, 49) == 0);
      poison_i = ($urandom_range(0, 7) == 0);
      if ($urandom_range(0, 15) == 0)
        set_levels(1'($urandom), priv_of($urandom_range(0, 2)), 1'($urandom), 1'($urandom));
      advance();
    end
    sweep_ram();
    repeat (3) advance();
    if (exp_q.size() != 0) begin
      $display("%0d expected responses were never returned", exp_q.size());
      abort_run();
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

//--- tb.f
logic/mmu_pkg.sv
logic/dtlb.sv
logic/access_check.sv
logic/data_ram.sv
logic/mem_top.sv
tests/mem_top_asserts.sv
tests/mem_top_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mem_top_tb \
  -f tb.f -Mdir obj_dir -o mem_top_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/mem_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "simulation finished without failures"
exit 0
